// File: Makefile
# Verilator build and run of the avrLite testbench

VERILATOR ?= verilator
TOP       ?= avrLiteTb
FILELIST  ?= avrLite.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TB PASSED

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: avrLite.f
+incdir+verilog
+incdir+verification
verilog/avrLitePkg.sv
verilog/programMemory.sv
verilog/registerFile.sv
verilog/instructionDecoder.sv
verilog/executeUnit.sv
verilog/hostPort.sv
verilog/avrLiteTop.sv
verification/avrLiteTb.sv

// File: verification/avrLiteTests.svh
// Instruction encoders, reference ALU model, host helpers and the directed test tasks
`ifndef AVR_LITE_TESTS_SVH
`define AVR_LITE_TESTS_SVH

// AVR opcode prefixes
localparam logic [3:0] prefixLdi = 4'b1110;
localparam logic [3:0] prefixSubi = 4'b0101;
localparam logic [3:0] prefixAndi = 4'b0111;
localparam logic [3:0] prefixCpi = 4'b0011;
localparam logic [5:0] prefixAdd = 6'b000011;
localparam logic [5:0] prefixAdc = 6'b000111;
localparam logic [5:0] prefixSub = 6'b000110;
localparam logic [5:0] prefixAnd = 6'b001000;
localparam logic [5:0] prefixEor = 6'b001001;
localparam logic [5:0] prefixOr = 6'b001010;
localparam logic [5:0] prefixMov = 6'b001011;

int progPointer; // Next program word address

// Immediate forms only reach r16 to r31
function automatic logic [15:0] encodeImm(input logic [3:0] prefix, input int rd,
	input logic [7:0] k);
	logic [4:0] d;
	d = 5'(rd);
	return {prefix, k[7:4], d[3:0], k[3:0]};
endfunction

function automatic logic [15:0] encodeRegOp(input logic [5:0] prefix, input int rd, input int rr);
	logic [4:0] d;
	logic [4:0] r;
	d = 5'(rd);
	r = 5'(rr);
	return {prefix, r[4], d, r[3:0]};
endfunction

function automatic logic [15:0] encodeOut(input logic [5:0] io, input int rr);
	logic [4:0] r;
	r = 5'(rr);
	return {5'b10111, io[5:4], r, io[3:0]};
endfunction

function automatic logic [15:0] encodeJump(input int k);
	logic [11:0] offset;
	offset = 12'(k);
	return {4'b1100, offset};
endfunction

function automatic logic [15:0] encodeBranch(input logic notEqual, input int k);
	logic [6:0] offset;
	offset = 7'(k);
	return {4'b1111, 1'b0, notEqual, offset, 3'b001}; // breq when notEqual is low
endfunction

// Result in the low byte and SREG in the high byte
function automatic logic [15:0] modelAlu(input avrLitePkg::opcode op, input logic [7:0] a,
	input logic [7:0] b, input logic [7:0] sregIn);
	logic [8:0] wide;
	logic [7:0] flags;
	flags = sregIn;
	case (op)
		avrLitePkg::opAdd: wide = {1'b0, a} + {1'b0, b};
		avrLitePkg::opAdc: wide = {1'b0, a} + {1'b0, b} + {8'b0, sregIn[`AVR_SREG_C]};
		avrLitePkg::opSub, avrLitePkg::opSubi, avrLitePkg::opCpi: wide = {1'b0, a} - {1'b0, b};
		avrLitePkg::opAnd, avrLitePkg::opAndi: wide = {1'b0, a & b};
		avrLitePkg::opOr: wide = {1'b0, a | b};
		avrLitePkg::opEor: wide = {1'b0, a ^ b};
		default: wide = {1'b0, a};
	endcase
	if (op inside {avrLitePkg::opAdd, avrLitePkg::opAdc, avrLitePkg::opSub, avrLitePkg::opSubi,
		avrLitePkg::opCpi})
		flags[`AVR_SREG_C] = wide[8]; // Logic ops keep C
	flags[`AVR_SREG_Z] = (wide[7:0] == 8'h00);
	flags[`AVR_SREG_N] = wide[7];
	flags[`AVR_SREG_V] = 1'b0;
	flags[`AVR_SREG_S] = flags[`AVR_SREG_N] ^ flags[`AVR_SREG_V];
	return {flags, wide[7:0]};
endfunction

function automatic logic [`AVR_HOST_ADDR_WIDTH-1:0] hostRegAddress(input avrLitePkg::hostReg r);
	return {5'b0, r};
endfunction

function automatic logic [`AVR_HOST_ADDR_WIDTH-1:0] fileRegAddress(input int n);
	return 11'(int'(avrLitePkg::regFileBase) + n);
endfunction

function automatic avrLitePkg::opcode pickAluOp(input int index);
	case (index)
		0: return avrLitePkg::opAdd;
		1: return avrLitePkg::opAdc;
		2: return avrLitePkg::opSub;
		3: return avrLitePkg::opAnd;
		4: return avrLitePkg::opOr;
		5: return avrLitePkg::opEor;
		default: return avrLitePkg::opAndi;
	endcase
endfunction

// Operands sit in r16 and r17 and andi takes its immediate
function automatic logic [15:0] encodeAluOp(input avrLitePkg::opcode op, input logic [7:0] k);
	case (op)
		avrLitePkg::opAdd: return encodeRegOp(prefixAdd, 16, 17);
		avrLitePkg::opAdc: return encodeRegOp(prefixAdc, 16, 17);
		avrLitePkg::opSub: return encodeRegOp(prefixSub, 16, 17);
		avrLitePkg::opAnd: return encodeRegOp(prefixAnd, 16, 17);
		avrLitePkg::opOr: return encodeRegOp(prefixOr, 16, 17);
		avrLitePkg::opEor: return encodeRegOp(prefixEor, 16, 17);
		default: return encodeImm(prefixAndi, 16, k);
	endcase
endfunction

task automatic writeControl(input logic [15:0] value);
	wbWrite(hostRegAddress(avrLitePkg::regControl), value);
endtask

// Core reset and halt with the program pointer back at zero
task automatic beginProgram();
	writeControl(16'h0004);
	progPointer = 0;
endtask

task automatic emitWord(input logic [15:0] word);
	wbWrite({1'b1, 10'(progPointer)}, word);
	progPointer++;
endtask

task automatic haltInFetch();
	logic [15:0] word;
	int polls;
	polls = 0;
	writeControl(16'h0000);
	wbRead(hostRegAddress(avrLitePkg::regStatus), word);
	if (word[2:0] !== avrLitePkg::fetch)
		writeControl(16'h0002); // Step finishes the instruction in flight
	while (word[2:0] !== avrLitePkg::fetch && polls < pollLimit)
	begin
		wbRead(hostRegAddress(avrLitePkg::regStatus), word);
		polls++;
	end
	if (word[2:0] !== avrLitePkg::fetch)
	begin
		timeoutCount++;
		$display("Timeout at %0t: core did not settle in fetch after halt", $time);
	end
endtask

task automatic runUntilPc(input logic [15:0] endPc);
	writeControl(16'h0001);
	waitForPc(endPc);
	haltInFetch();
endtask

task automatic expectHost(input avrLitePkg::hostReg r, input logic [15:0] expected,
	input string what);
	logic [15:0] word;
	wbRead(hostRegAddress(r), word);
	checkWord(word, expected, what);
endtask

task automatic expectReg(input int n, input logic [7:0] expected, input string what);
	logic [15:0] word;
	wbRead(fileRegAddress(n), word);
	checkByte(word[7:0], expected, what);
endtask

task automatic expectStatus(input logic [7:0] sregValue, input avrLitePkg::coreState st,
	input string what);
	logic [15:0] word;
	wbRead(hostRegAddress(avrLitePkg::regStatus), word);
	checkByte(word[15:8], sregValue, {what, " SREG"});
	checkState(avrLitePkg::coreState'(word[2:0]), st, {what, " state"});
endtask

task automatic resetStateTest();
	expectHost(avrLitePkg::regPc, 16'h0000, "PC after reset");
	expectStatus(8'h00, avrLitePkg::fetch, "after reset");
	expectHost(avrLitePkg::regPins, 16'h0000, "ioPins readback after reset");
	checkWord(ioPins, 16'h0000, "ioPins after reset");
	checkWord({15'b0, stuck}, 16'h0000, "stuck after reset");
endtask

task automatic programLoadTest();
	logic [7:0] valueB;
	logic [7:0] valueD;
	valueB = 8'hC3;
	valueD = 8'h5A;
	beginProgram();
	emitWord(encodeImm(prefixLdi, 16, valueD));
	emitWord(encodeImm(prefixLdi, 17, valueB));
	emitWord(encodeRegOp(prefixMov, 2, 16));
	emitWord(encodeOut(`AVR_IO_PORTB, 17));
	emitWord(encodeOut(`AVR_IO_PORTD, 2));
	emitWord(encodeJump(-1)); // Parks at 5
	runUntilPc(16'd5);
	expectReg(16, valueD, "r16 after ldi");
	expectReg(17, valueB, "r17 after ldi");
	expectReg(2, valueD, "r2 after mov");
	expectHost(avrLitePkg::regPins, {valueB, valueD}, "ioPins readback after out");
	checkWord(ioPins, {valueB, valueD}, "ioPins after out");
	expectStatus(8'h00, avrLitePkg::fetch, "after ldi and mov");
endtask

task automatic countdownLoopTest();
	logic [7:0] count;
	logic [15:0] expected;
	count = 8'd7;
	expected = modelAlu(avrLitePkg::opCpi, count, count, 8'h00);
	beginProgram();
	emitWord(encodeImm(prefixLdi, 20, count));
	emitWord(encodeImm(prefixLdi, 21, 8'h00));
	emitWord(encodeImm(prefixLdi, 22, 8'h00));
	emitWord(encodeImm(prefixSubi, 21, 8'hFF)); // Counter up by one
	emitWord(encodeImm(prefixSubi, 20, 8'h01));
	emitWord(encodeBranch(1'b1, -3));
	emitWord(encodeOut(`AVR_IO_PORTD, 21));
	emitWord(encodeImm(prefixCpi, 21, count));
	emitWord(encodeBranch(1'b0, 1)); // Over the marker
	emitWord(encodeImm(prefixLdi, 22, 8'hEE));
	emitWord(encodeImm(prefixLdi, 23, 8'h77));
	emitWord(encodeJump(-1));
	runUntilPc(16'd11);
	expectHost(avrLitePkg::regPins, {8'h00, count}, "ioPins after countdown");
	expectReg(20, 8'h00, "r20 after countdown");
	expectReg(21, count, "r21 iteration count");
	expectReg(22, 8'h00, "r22 marker skipped by breq");
	expectReg(23, 8'h77, "r23 after breq target");
	expectStatus(expected[15:8], avrLitePkg::fetch, "after cpi");
endtask

task automatic stepAndCheck(input logic [15:0] target);
	writeControl(16'h0002);
	waitForPc(target);
	expectHost(avrLitePkg::regPc, target, "PC held after step");
	expectStatus(8'h00, avrLitePkg::fetch, "after step");
endtask

task automatic singleStepTest();
	beginProgram();
	emitWord(encodeImm(prefixLdi, 24, 8'h11));
	emitWord(encodeJump(2));
	emitWord(16'h0000);
	emitWord(16'h0000);
	emitWord(encodeImm(prefixLdi, 25, 8'h22));
	emitWord(encodeJump(-6)); // Back to 0
	stepAndCheck(16'd1);
	expectReg(24, 8'h11, "r24 after first step");
	stepAndCheck(16'd4);
	stepAndCheck(16'd5);
	expectReg(25, 8'h22, "r25 after third step");
	stepAndCheck(16'd0);
	stepAndCheck(16'd1);
endtask

task automatic randomAluTest();
	logic [31:0] rndA;
	logic [31:0] rndB;
	logic [7:0] a;
	logic [7:0] b;
	logic carryIn;
	logic [15:0] afterAdd;
	logic [15:0] expected;
	avrLitePkg::opcode op;
	for (int i = 0; i < 14; i++)
	begin
		rndA = nextRandom();
		rndB = nextRandom();
		a = rndA[31:24];
		b = rndB[31:24];
		op = pickAluOp(i % 7); // Every op once with each carry in
		carryIn = (i >= 7);
		afterAdd = modelAlu(avrLitePkg::opAdd, 8'hFF, {7'b0, carryIn}, 8'h00);
		expected = modelAlu(op, a, b, afterAdd[15:8]);
		beginProgram();
		emitWord(encodeImm(prefixLdi, 18, 8'hFF));
		emitWord(encodeImm(prefixLdi, 19, {7'b0, carryIn}));
		emitWord(encodeRegOp(prefixAdd, 18, 19)); // Sets C for adc
		emitWord(encodeImm(prefixLdi, 16, a));
		emitWord(encodeImm(prefixLdi, 17, b));
		emitWord(encodeAluOp(op, b));
		emitWord(encodeJump(-1));
		runUntilPc(16'd6);
		expectReg(16, expected[7:0], $sformatf("%s of %02h and %02h", op.name(), a, b));
		expectReg(17, b, "r17 second operand");
		expectStatus(expected[15:8], avrLitePkg::fetch, $sformatf("%s", op.name()));
	end
endtask

task automatic stuckOpcodeTest();
	int waitCycles;
	waitCycles = 0;
	beginProgram();
	emitWord(encodeImm(prefixLdi, 26, 8'h33));
	emitWord(16'h9508); // ret is undefined in this core
	emitWord(encodeImm(prefixLdi, 27, 8'h44));
	emitWord(encodeJump(-1));
	writeControl(16'h0001);
	while (!stuck && waitCycles < pollLimit)
	begin
		nextCycle();
		waitCycles++;
	end
	if (!stuck)
	begin
		timeoutCount++;
		$display("Timeout at %0t: core never entered the stuck state", $time);
	end
	expectHost(avrLitePkg::regPc, 16'd1, "PC at undefined word");
	expectStatus(8'h00, avrLitePkg::stuck, "on undefined word");
	expectReg(26, 8'h33, "r26 before undefined word");
	expectReg(27, 8'h00, "r27 after undefined word");
	repeat (12) nextCycle();
	expectHost(avrLitePkg::regPc, 16'd1, "PC held while stuck");
	writeControl(16'h0004);
	expectHost(avrLitePkg::regPc, 16'h0000, "PC after core reset");
	expectStatus(8'h00, avrLitePkg::fetch, "after core reset");
	checkWord({15'b0, stuck}, 16'h0000, "stuck after core reset");
endtask

`endif

// File: verification/avrLiteTb.sv
// Testbench top with clock and reset, Wishbone master tasks, compare tasks, LCG and result line
`include "avrLite_config.svh"

module avrLiteTb;
	localparam int driveDelay = 5; // Inputs change this long after the rising edge
	localparam int ackTimeout = 16;
	localparam int pollLimit = 300;

	logic clk;
	logic reseted;
	logic [`AVR_HOST_ADDR_WIDTH-1:0] wbAdr;
	logic [`AVR_WORD_WIDTH-1:0] wbDatWr;
	logic wbWe;
	logic wbStb;
	logic wbCyc;
	logic [`AVR_WORD_WIDTH-1:0] wbDatRd;
	logic wbAck;
	logic [`AVR_WORD_WIDTH-1:0] ioPins;
	logic stuck;
	int checkCount;
	int errorCount;
	int timeoutCount;
	logic [31:0] lcgState;

	avrLiteTop dut
	(
		.clk(clk), .reseted(reseted),
		.wbAdr(wbAdr), .wbDatWr(wbDatWr), .wbWe(wbWe), .wbStb(wbStb), .wbCyc(wbCyc),
		.wbDatRd(wbDatRd), .wbAck(wbAck), .ioPins(ioPins), .stuck(stuck)
	);

	always #50 clk = ~clk;

	task automatic nextCycle();
		@(posedge clk);
		#driveDelay;
	endtask

	function logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// One classic cycle with the signals held until ack
	task automatic wbAccess(input logic [`AVR_HOST_ADDR_WIDTH-1:0] addr,
		input logic [`AVR_WORD_WIDTH-1:0] data, input logic write,
		output logic [`AVR_WORD_WIDTH-1:0] readData);
		int waitCycles;
		waitCycles = 0;
		wbAdr = addr;
		wbDatWr = data;
		wbWe = write;
		wbStb = 1'b1;
		wbCyc = 1'b1;
		nextCycle();
		while (!wbAck && waitCycles < ackTimeout)
		begin
			nextCycle();
			waitCycles++;
		end
		if (!wbAck)
		begin
			timeoutCount++;
			$display("Timeout at %0t: no Wishbone ack for address %03h", $time, addr);
		end
		readData = wbDatRd; // Registered data arrives with ack
		wbStb = 1'b0;
		wbCyc = 1'b0;
		wbWe = 1'b0;
		nextCycle(); // Slave sees the strobe fall before the next access
	endtask

	task automatic wbWrite(input logic [`AVR_HOST_ADDR_WIDTH-1:0] addr,
		input logic [`AVR_WORD_WIDTH-1:0] data);
		logic [`AVR_WORD_WIDTH-1:0] unused;
		wbAccess(addr, data, 1'b1, unused);
	endtask

	task automatic wbRead(input logic [`AVR_HOST_ADDR_WIDTH-1:0] addr,
		output logic [`AVR_WORD_WIDTH-1:0] data);
		wbAccess(addr, 16'h0000, 1'b0, data);
	endtask

	task automatic waitForPc(input logic [`AVR_WORD_WIDTH-1:0] target);
		logic [`AVR_WORD_WIDTH-1:0] pc;
		int polls;
		polls = 0;
		wbRead({5'b0, avrLitePkg::regPc}, pc);
		while (pc !== target && polls < pollLimit)
		begin
			wbRead({5'b0, avrLitePkg::regPc}, pc);
			polls++;
		end
		if (pc !== target)
		begin
			timeoutCount++;
			$display("Timeout at %0t: PC never reached %04h, last read %04h", $time, target, pc);
		end
	endtask

	task automatic checkWord(input logic [`AVR_WORD_WIDTH-1:0] actual,
		input logic [`AVR_WORD_WIDTH-1:0] expected, input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("error at time %0t: %s is %04h, expected %04h", $time, what, actual, expected);
		end
	endtask

	task automatic checkByte(input logic [`AVR_DATA_WIDTH-1:0] actual,
		input logic [`AVR_DATA_WIDTH-1:0] expected, input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("error at time %0t: %s is %02h, expected %02h", $time, what, actual, expected);
		end
	endtask

	task automatic checkState(input avrLitePkg::coreState actual,
		input avrLitePkg::coreState expected, input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("error at time %0t: %s is %s, expected %s", $time, what, actual.name(),
				expected.name());
		end
	endtask

	`include "avrLiteTests.svh"

	initial
	begin
		clk = 1'b0;
		reseted = 1'b1;
		wbAdr = '0;
		wbDatWr = '0;
		wbWe = 1'b0;
		wbStb = 1'b0;
		wbCyc = 1'b0;
		checkCount = 0;
		errorCount = 0;
		timeoutCount = 0;
		lcgState = 32'h849;
		progPointer = 0;
		repeat (10) @(posedge clk);
		#driveDelay;
		reseted = 1'b0;

		resetStateTest();
		programLoadTest();
		countdownLoopTest();
		singleStepTest();
		randomAluTest();
		stuckOpcodeTest();

		$display("Result: %0d checks, %0d errors, %0d timeouts", checkCount, errorCount,
			timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: verilog/avrLitePkg.sv
// Core state, opcode and host register address enums
package avrLitePkg;

	typedef enum logic [2:0]
	{
		fetch     = 3'd0, // PC on the program memory address
		fetchWait = 3'd1, // Word arrives and is latched
		decode    = 3'd2,
		work1     = 3'd3,
		work2     = 3'd4,
		work3     = 3'd5,
		stuck     = 3'd6  // Left only by a reset
	} coreState;

	typedef enum logic [4:0]
	{
		opNop,
		opLdi,
		opMov,
		opAdd,
		opAdc,
		opSub,
		opSubi,
		opAnd,
		opAndi,
		opOr,
		opOri,
		opEor,
		opCpi,
		opRjmp,
		opBreq,
		opBrne,
		opOut,
		opError
	} opcode;

	// Host register window, r0 to r31 follow regFileBase
	typedef enum logic [5:0]
	{
		regControl  = 6'd0,
		regPc       = 6'd1,
		regStatus   = 6'd2,
		regPins     = 6'd3,
		regFileBase = 6'd32
	} hostReg;

endpackage

// File: verilog/avrLiteTop.sv
// Top level wiring the Wishbone host port, program memory, decoder, register file and core
`include "avrLite_config.svh"

module avrLiteTop
(
	input  logic clk,
	input  logic reseted,
	input  logic [`AVR_HOST_ADDR_WIDTH-1:0] wbAdr,
	input  logic [`AVR_WORD_WIDTH-1:0] wbDatWr,
	input  logic wbWe,
	input  logic wbStb,
	input  logic wbCyc,
	output logic [`AVR_WORD_WIDTH-1:0] wbDatRd,
	output logic wbAck,
	output logic [`AVR_WORD_WIDTH-1:0] ioPins,
	output logic stuck
);
	logic [`AVR_WORD_WIDTH-1:0] pc;
	logic [`AVR_DATA_WIDTH-1:0] sreg;
	avrLitePkg::coreState state;
	logic progWrEn;
	logic [`AVR_PROG_ADDR_WIDTH-1:0] progWrAddr;
	logic [`AVR_WORD_WIDTH-1:0] progWrData;
	logic [`AVR_REG_ADDR_WIDTH-1:0] hostRegAddr;
	logic [`AVR_DATA_WIDTH-1:0] hostRegData;
	logic run;
	logic stepPulse;
	logic coreReset;
	logic [`AVR_WORD_WIDTH-1:0] instrWord;    // Raw memory output
	logic [`AVR_WORD_WIDTH-1:0] fetchedInstr; // Latched in fetchWait
	avrLitePkg::opcode op;
	logic [`AVR_REG_ADDR_WIDTH-1:0] rd;
	logic [`AVR_REG_ADDR_WIDTH-1:0] rr;
	logic [`AVR_DATA_WIDTH-1:0] imm;
	logic [`AVR_WORD_WIDTH-1:0] branchOffset;
	logic [5:0] ioAddr;
	logic [`AVR_REG_ADDR_WIDTH-1:0] regAddrA;
	logic [`AVR_REG_ADDR_WIDTH-1:0] regAddrB;
	logic [`AVR_DATA_WIDTH-1:0] dataA;
	logic [`AVR_DATA_WIDTH-1:0] dataB;
	logic regWrEn;
	logic [`AVR_REG_ADDR_WIDTH-1:0] regWrAddr;
	logic [`AVR_DATA_WIDTH-1:0] regWrData;

	hostPort hostPortInst (
		.clk(clk), .reseted(reseted),
		.wbAdr(wbAdr), .wbDatWr(wbDatWr), .wbWe(wbWe), .wbStb(wbStb), .wbCyc(wbCyc),
		.pc(pc), .sreg(sreg), .state(state), .ioPins(ioPins), .hostRegData(hostRegData),
		.wbDatRd(wbDatRd), .wbAck(wbAck),
		.progWrEn(progWrEn), .progWrAddr(progWrAddr), .progWrData(progWrData),
		.hostRegAddr(hostRegAddr),
		.run(run), .stepPulse(stepPulse), .coreReset(coreReset)
	);

	programMemory programMemoryInst (
		.clk(clk), .rdAddr(pc[`AVR_PROG_ADDR_WIDTH-1:0]),
		.wrEn(progWrEn), .wrAddr(progWrAddr), .wrData(progWrData),
		.rdData(instrWord)
	);

	instructionDecoder decoderInst (
		.instr(fetchedInstr), .op(op), .rd(rd), .rr(rr), .imm(imm),
		.branchOffset(branchOffset), .ioAddr(ioAddr)
	);

	registerFile registerFileInst (
		.clk(clk), .reseted(reseted),
		.addrA(regAddrA), .addrB(regAddrB), .hostAddr(hostRegAddr),
		.wrEn(regWrEn), .wrAddr(regWrAddr), .wrData(regWrData),
		.dataA(dataA), .dataB(dataB), .hostData(hostRegData)
	);

	executeUnit executeUnitInst (
		.clk(clk), .reseted(reseted), .coreReset(coreReset), .run(run), .stepPulse(stepPulse),
		.instrWord(instrWord), .op(op), .rd(rd), .rr(rr), .imm(imm),
		.branchOffset(branchOffset), .ioAddr(ioAddr), .dataA(dataA), .dataB(dataB),
		.pc(pc), .sreg(sreg), .state(state), .fetchedInstr(fetchedInstr),
		.regAddrA(regAddrA), .regAddrB(regAddrB),
		.regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
		.ioPins(ioPins), .stuck(stuck)
	);

endmodule

// File: verilog/avrLite_config.svh
// Widths, program memory depth, IO addresses, SREG bit positions and host address map
`ifndef AVR_LITE_CONFIG_SVH
`define AVR_LITE_CONFIG_SVH

`define AVR_DATA_WIDTH 8       // Register and port width
`define AVR_WORD_WIDTH 16      // Instruction word and host data
`define AVR_PROG_ADDR_WIDTH 10
`define AVR_PROG_DEPTH (1 << `AVR_PROG_ADDR_WIDTH)
`define AVR_REG_COUNT 32
`define AVR_REG_ADDR_WIDTH 5

// IO space targets of out
`define AVR_IO_PORTB 6'd5
`define AVR_IO_PORTD 6'd11

`define AVR_SREG_C 0
`define AVR_SREG_Z 1
`define AVR_SREG_N 2
`define AVR_SREG_V 3
`define AVR_SREG_S 4

`define AVR_HOST_ADDR_WIDTH 11
`define AVR_HOST_PROG_BIT 10   // Set selects program memory

`endif

// File: verilog/executeUnit.sv
// Multicycle core FSM with PC, SREG, ALU, output ports and the stuck state
`include "avrLite_config.svh"

module executeUnit
(
	input  logic clk,
	input  logic reseted,
	input  logic coreReset,
	input  logic run,
	input  logic stepPulse,
	input  logic [`AVR_WORD_WIDTH-1:0] instrWord,
	input  avrLitePkg::opcode op,
	input  logic [`AVR_REG_ADDR_WIDTH-1:0] rd,
	input  logic [`AVR_REG_ADDR_WIDTH-1:0] rr,
	input  logic [`AVR_DATA_WIDTH-1:0] imm,
	input  logic [`AVR_WORD_WIDTH-1:0] branchOffset,
	input  logic [5:0] ioAddr,
	input  logic [`AVR_DATA_WIDTH-1:0] dataA,
	input  logic [`AVR_DATA_WIDTH-1:0] dataB,
	output logic [`AVR_WORD_WIDTH-1:0] pc,
	output logic [`AVR_DATA_WIDTH-1:0] sreg,
	output avrLitePkg::coreState state,
	output logic [`AVR_WORD_WIDTH-1:0] fetchedInstr,
	output logic [`AVR_REG_ADDR_WIDTH-1:0] regAddrA,
	output logic [`AVR_REG_ADDR_WIDTH-1:0] regAddrB,
	output logic regWrEn,
	output logic [`AVR_REG_ADDR_WIDTH-1:0] regWrAddr,
	output logic [`AVR_DATA_WIDTH-1:0] regWrData,
	output logic [`AVR_WORD_WIDTH-1:0] ioPins,
	output logic stuck
);
	logic advance;
	logic stepping; // Finishing one instruction for a step request
	logic [`AVR_DATA_WIDTH-1:0] portB;
	logic [`AVR_DATA_WIDTH-1:0] portD;
	logic [`AVR_DATA_WIDTH-1:0] aluResult;
	logic aluCarry;
	logic [`AVR_DATA_WIDTH-1:0] resultReg;
	logic carryReg;
	logic writesReg;
	logic setsFlags;
	logic setsCarry;
	logic branchTaken;

	assign advance = run || stepping;
	assign stuck = (state == avrLitePkg::stuck);
	assign ioPins = {portB, portD};

	assign writesReg = op inside {avrLitePkg::opLdi, avrLitePkg::opMov, avrLitePkg::opAdd,
		avrLitePkg::opAdc, avrLitePkg::opSub, avrLitePkg::opSubi, avrLitePkg::opAnd,
		avrLitePkg::opAndi, avrLitePkg::opOr, avrLitePkg::opOri, avrLitePkg::opEor};
	assign setsFlags = writesReg && !(op inside {avrLitePkg::opLdi, avrLitePkg::opMov})
		|| (op == avrLitePkg::opCpi);
	assign setsCarry = op inside {avrLitePkg::opAdd, avrLitePkg::opAdc, avrLitePkg::opSub,
		avrLitePkg::opSubi, avrLitePkg::opCpi};
	assign branchTaken = (op == avrLitePkg::opRjmp)
		|| (op == avrLitePkg::opBreq && sreg[`AVR_SREG_Z])
		|| (op == avrLitePkg::opBrne && !sreg[`AVR_SREG_Z]);

	// Ninth bit is carry out for adds and borrow for subtracts
	always_comb
	begin
		aluCarry = sreg[`AVR_SREG_C];
		aluResult = dataA;
		case (op)
			avrLitePkg::opLdi: aluResult = imm;
			avrLitePkg::opMov: aluResult = dataB;
			avrLitePkg::opAdd: {aluCarry, aluResult} = {1'b0, dataA} + {1'b0, dataB};
			avrLitePkg::opAdc:
			begin
				{aluCarry, aluResult} = {1'b0, dataA} + {1'b0, dataB}
					+ {8'b0, sreg[`AVR_SREG_C]};
			end
			avrLitePkg::opSub: {aluCarry, aluResult} = {1'b0, dataA} - {1'b0, dataB};
			avrLitePkg::opSubi,
			avrLitePkg::opCpi: {aluCarry, aluResult} = {1'b0, dataA} - {1'b0, imm};
			avrLitePkg::opAnd: aluResult = dataA & dataB;
			avrLitePkg::opAndi: aluResult = dataA & imm;
			avrLitePkg::opOr: aluResult = dataA | dataB;
			avrLitePkg::opOri: aluResult = dataA | imm;
			avrLitePkg::opEor: aluResult = dataA ^ dataB;
			default: aluResult = dataA;
		endcase
	end

	assign regWrEn = advance && (state == avrLitePkg::work2) && writesReg;
	assign regWrAddr = regAddrA;
	assign regWrData = aluResult;

	always_ff @(posedge clk)
	begin
		if (reseted || coreReset)
		begin
			state <= avrLitePkg::fetch;
			pc <= '0;
			sreg <= '0;
			portB <= '0;
			portD <= '0;
			stepping <= 1'b0;
		end
		else
		begin
			if (stepPulse)
				stepping <= 1'b1;
			else if (advance && state == avrLitePkg::work3)
				stepping <= 1'b0; // Hold in fetch after the step
			if (advance)
			begin
				case (state)
					avrLitePkg::fetch:     state <= avrLitePkg::fetchWait;
					avrLitePkg::fetchWait: state <= avrLitePkg::decode;
					avrLitePkg::decode:    state <= avrLitePkg::work1;
					avrLitePkg::work1:
					begin
						state <= (op == avrLitePkg::opError) ? avrLitePkg::stuck
							: avrLitePkg::work2;
					end
					avrLitePkg::work2:
					begin
						if (op == avrLitePkg::opOut && ioAddr == `AVR_IO_PORTB)
							portB <= dataA;
						else if (op == avrLitePkg::opOut && ioAddr == `AVR_IO_PORTD)
							portD <= dataA;
						state <= avrLitePkg::work3;
					end
					avrLitePkg::work3:
					begin
						if (setsFlags)
						begin
							sreg[`AVR_SREG_Z] <= (resultReg == '0);
							sreg[`AVR_SREG_N] <= resultReg[`AVR_DATA_WIDTH-1];
							sreg[`AVR_SREG_V] <= 1'b0;
							sreg[`AVR_SREG_S] <= resultReg[`AVR_DATA_WIDTH-1]; // N xor V, V clear
						end
						if (setsCarry)
							sreg[`AVR_SREG_C] <= carryReg;
						pc <= branchTaken ? pc + 16'd1 + branchOffset : pc + 16'd1;
						state <= avrLitePkg::fetch;
					end
					default: state <= state; // Stuck until a reset
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance && state == avrLitePkg::fetchWait)
			fetchedInstr <= instrWord;
		if (advance && state == avrLitePkg::work1)
		begin
			regAddrA <= rd;
			regAddrB <= rr;
		end
		if (advance && state == avrLitePkg::work2)
		begin
			resultReg <= aluResult; // Flags follow in work3
			carryReg <= aluCarry;
		end
	end

endmodule

// File: verilog/hostPort.sv
// Wishbone classic slave for program load, run and step control, status and register readback
`include "avrLite_config.svh"

module hostPort
(
	input  logic clk,
	input  logic reseted,
	input  logic [`AVR_HOST_ADDR_WIDTH-1:0] wbAdr,
	input  logic [`AVR_WORD_WIDTH-1:0] wbDatWr,
	input  logic wbWe,
	input  logic wbStb,
	input  logic wbCyc,
	input  logic [`AVR_WORD_WIDTH-1:0] pc,
	input  logic [`AVR_DATA_WIDTH-1:0] sreg,
	input  avrLitePkg::coreState state,
	input  logic [`AVR_WORD_WIDTH-1:0] ioPins,
	input  logic [`AVR_DATA_WIDTH-1:0] hostRegData,
	output logic [`AVR_WORD_WIDTH-1:0] wbDatRd,
	output logic wbAck,
	output logic progWrEn,
	output logic [`AVR_PROG_ADDR_WIDTH-1:0] progWrAddr,
	output logic [`AVR_WORD_WIDTH-1:0] progWrData,
	output logic [`AVR_REG_ADDR_WIDTH-1:0] hostRegAddr,
	output logic run,
	output logic stepPulse,
	output logic coreReset
);
	logic accept;      // New access sampled this cycle
	logic waitRelease; // Ack done, stb still up
	logic progSel;
	logic regSel;
	logic controlWr;
	logic [5:0] regIndex;
	logic [`AVR_WORD_WIDTH-1:0] readMux;

	assign accept = wbCyc && wbStb && !waitRelease;
	assign progSel = wbAdr[`AVR_HOST_PROG_BIT];
	assign regIndex = wbAdr[5:0];
	assign regSel = !progSel && (wbAdr[`AVR_HOST_PROG_BIT-1:6] == '0);
	assign controlWr = accept && wbWe && regSel && (regIndex == avrLitePkg::regControl);

	assign progWrEn = accept && wbWe && progSel;
	assign progWrAddr = wbAdr[`AVR_PROG_ADDR_WIDTH-1:0];
	assign progWrData = wbDatWr;
	assign hostRegAddr = wbAdr[`AVR_REG_ADDR_WIDTH-1:0]; // rn at regFileBase+n

	always_comb
	begin
		readMux = '0;
		if (regSel)
		begin
			if (regIndex >= avrLitePkg::regFileBase)
				readMux = {{(`AVR_WORD_WIDTH-`AVR_DATA_WIDTH){1'b0}}, hostRegData};
			else
			begin
				case (regIndex)
					avrLitePkg::regControl: readMux = {15'b0, run};
					avrLitePkg::regPc:      readMux = pc;
					avrLitePkg::regStatus:  readMux = {sreg, 5'b0, state}; // SREG high, state low
					avrLitePkg::regPins:    readMux = ioPins;
					default:                readMux = '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reseted)
		begin
			wbAck <= 1'b0;
			waitRelease <= 1'b0;
			run <= 1'b0;
			stepPulse <= 1'b0;
			coreReset <= 1'b0;
		end
		else
		begin
			wbAck <= accept; // One cycle after first sample
			if (accept)
				waitRelease <= 1'b1;
			else if (!wbStb)
				waitRelease <= 1'b0;
			stepPulse <= controlWr && wbDatWr[1];
			coreReset <= controlWr && wbDatWr[2];
			if (controlWr)
				run <= wbDatWr[0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			wbDatRd <= readMux;
	end

endmodule

// File: verilog/instructionDecoder.sv
// AVR instruction word decode into opcode, register fields, immediate, branch offset and IO address
`include "avrLite_config.svh"

module instructionDecoder
(
	input  logic [`AVR_WORD_WIDTH-1:0] instr,
	output avrLitePkg::opcode op,
	output logic [`AVR_REG_ADDR_WIDTH-1:0] rd,
	output logic [`AVR_REG_ADDR_WIDTH-1:0] rr,
	output logic [`AVR_DATA_WIDTH-1:0] imm,
	output logic [`AVR_WORD_WIDTH-1:0] branchOffset,
	output logic [5:0] ioAddr
);
	logic upperHalf; // Immediate forms only reach r16 to r31

	always_comb
	begin
		casez (instr)
			16'b0000_0000_0000_0000: op = avrLitePkg::opNop;
			16'b0000_11??_????_????: op = avrLitePkg::opAdd;
			16'b0001_11??_????_????: op = avrLitePkg::opAdc;
			16'b0001_10??_????_????: op = avrLitePkg::opSub;
			16'b0010_00??_????_????: op = avrLitePkg::opAnd;
			16'b0010_01??_????_????: op = avrLitePkg::opEor;
			16'b0010_10??_????_????: op = avrLitePkg::opOr;
			16'b0010_11??_????_????: op = avrLitePkg::opMov;
			16'b0011_????_????_????: op = avrLitePkg::opCpi;
			16'b0101_????_????_????: op = avrLitePkg::opSubi;
			16'b0110_????_????_????: op = avrLitePkg::opOri;
			16'b0111_????_????_????: op = avrLitePkg::opAndi;
			16'b1011_1???_????_????: op = avrLitePkg::opOut;
			16'b1100_????_????_????: op = avrLitePkg::opRjmp;
			16'b1110_????_????_????: op = avrLitePkg::opLdi;
			16'b1111_00??_????_?001: op = avrLitePkg::opBreq;
			16'b1111_01??_????_?001: op = avrLitePkg::opBrne;
			default:                 op = avrLitePkg::opError;
		endcase
	end

	assign upperHalf = op inside {avrLitePkg::opLdi, avrLitePkg::opSubi, avrLitePkg::opAndi,
		avrLitePkg::opOri, avrLitePkg::opCpi};

	assign rd = upperHalf ? {1'b1, instr[7:4]} : instr[8:4]; // Also the out source
	assign rr = {instr[9], instr[3:0]};
	assign imm = {instr[11:8], instr[3:0]};
	assign ioAddr = {instr[10:9], instr[3:0]};

	// rjmp carries 12 bits, breq and brne carry 7
	assign branchOffset = (op == avrLitePkg::opRjmp) ? {{4{instr[11]}}, instr[11:0]}
		: {{9{instr[9]}}, instr[9:3]};

endmodule

// File: verilog/programMemory.sv
// Instruction memory with synchronous read and a host write port
`include "avrLite_config.svh"

module programMemory
(
	input  logic clk,
	input  logic [`AVR_PROG_ADDR_WIDTH-1:0] rdAddr,
	input  logic wrEn,
	input  logic [`AVR_PROG_ADDR_WIDTH-1:0] wrAddr,
	input  logic [`AVR_WORD_WIDTH-1:0] wrData,
	output logic [`AVR_WORD_WIDTH-1:0] rdData
);
	logic [`AVR_WORD_WIDTH-1:0] mem [`AVR_PROG_DEPTH];

	// Blank words decode as nop
	initial
	begin
		for (int i = 0; i < `AVR_PROG_DEPTH; i++)
		begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrAddr] <= wrData;
		rdData <= mem[rdAddr]; // Word valid the cycle after the address
	end

endmodule

// File: verilog/registerFile.sv
// General purpose registers r0 to r31 with two core read ports, a host read port and one write port
`include "avrLite_config.svh"

module registerFile
(
	input  logic clk,
	input  logic reseted,
	input  logic [`AVR_REG_ADDR_WIDTH-1:0] addrA,
	input  logic [`AVR_REG_ADDR_WIDTH-1:0] addrB,
	input  logic [`AVR_REG_ADDR_WIDTH-1:0] hostAddr,
	input  logic wrEn,
	input  logic [`AVR_REG_ADDR_WIDTH-1:0] wrAddr,
	input  logic [`AVR_DATA_WIDTH-1:0] wrData,
	output logic [`AVR_DATA_WIDTH-1:0] dataA,
	output logic [`AVR_DATA_WIDTH-1:0] dataB,
	output logic [`AVR_DATA_WIDTH-1:0] hostData
);
	logic [`AVR_DATA_WIDTH-1:0] regs [`AVR_REG_COUNT];

	always_ff @(posedge clk)
	begin
		if (reseted)
		begin
			for (int i = 0; i < `AVR_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wrEn)
			regs[wrAddr] <= wrData;
	end

	assign dataA = regs[addrA];
	assign dataB = regs[addrB];
	assign hostData = regs[hostAddr]; // Readback path, independent of the core

endmodule
